// ==== sim.f ====
src/dtwPkg.sv
src/dtwPathStore.sv
src/dtwTraceWalker.sv
src/dtwBacktrace.sv
verification/dtwBacktraceChk.sv
verification/dtwBacktraceTb.sv

// ==== Makefile ====
TOP := dtwBacktraceTb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): sim.f $(wildcard src/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== verification/dtwBacktraceTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtwBacktraceTb;

    localparam int NumPe         = 6;
    localparam int SeqLen        = 20;
    localparam int NumWords      = 2 * SeqLen - 1;
    localparam int WordWidth     = NumPe * dtwPkg::PathWidth;
    localparam int IndexWidth    = dtwPkg::IndexWidth;
    localparam int ScoreWidth    = dtwPkg::ScoreWidth;
    localparam int MaxSteps      = 45;
    localparam int BandHalf      = 4;  // Widest |r - t| a generated walk may reach.
    localparam int ClkPeriod     = 100;
    localparam int ResetCycles   = 16;
    localparam int TimeoutCycles = ResetCycles + 5 * (NumWords + MaxSteps) + 100;

    logic                         clk;
    logic                         nrst;
    logic [ScoreWidth-1:0]        i_score;
    logic [WordWidth-1:0]         i_path;
    logic                         i_btStart;
    logic                         i_btEna;
    logic                         o_btEnd;
    logic [dtwPkg::DataWidth-1:0] o_data;

    dtwPkg::pathDir_e      dirMem [NumWords][NumPe];  // Direction per iteration and PE.
    logic [IndexWidth-1:0] refTest [MaxSteps+1];
    logic [IndexWidth-1:0] refRef [MaxSteps+1];
    logic [ScoreWidth-1:0] curScore;
    logic [31:0]           lcgState;
    logic                  checking;
    int                    traceStep;
    int                    errCount;
    int                    testsRun;
    int                    testsFailed;
    int                    cycleCount;

    dtwBacktrace #(
        .NumPe  (NumPe),
        .SeqLen (SeqLen)
    ) UUT (
        .clk       (clk),
        .nrst      (nrst),
        .i_score   (i_score),
        .i_path    (i_path),
        .i_btStart (i_btStart),
        .i_btEna   (i_btEna),
        .o_btEnd   (o_btEnd),
        .o_data    (o_data)
    );

    bind dtwBacktrace dtwBacktraceChk portChk (
        .clk       (clk),
        .nrst      (nrst),
        .i_btEna   (i_btEna),
        .i_btStart (i_btStart),
        .o_btEnd   (o_btEnd),
        .o_data    (o_data)
    );

    always #(ClkPeriod / 2) clk = !clk;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // SRAM word: pad, test index, pad, reference index, score.
    function automatic logic [dtwPkg::DataWidth-1:0] dataWord(
        input logic [IndexWidth-1:0] t,
        input logic [IndexWidth-1:0] r,
        input logic [ScoreWidth-1:0] score
    );
        return {3'b000, t, 3'b000, r, score};
    endfunction

    // PE 0 sits in the top code of the word.
    function automatic logic [WordWidth-1:0] pathWord(input int k);
        logic [WordWidth-1:0] w;
        int                   p;
        w = '0;
        for (p = 0; p < NumPe; p++) begin
            w[WordWidth - 1 - p * dtwPkg::PathWidth -: dtwPkg::PathWidth] = dirMem[k][p];
        end
        return w;
    endfunction

    // Random fill, then a monotone walk from the corner written over it.
    function automatic void buildWalk();
        logic [31:0]      rnd;
        dtwPkg::pathDir_e mv;
        int               k;
        int               p;
        int               t;
        int               r;
        int               pick;
        int               diff;
        for (k = 0; k < NumWords; k++) begin
            for (p = 0; p < NumPe; p++) begin
                rnd = lcgNext();
                dirMem[k][p] = dtwPkg::pathDir_e'(rnd[17:16]);
            end
        end
        t = SeqLen - 1;
        r = SeqLen - 1;
        while (t > 0 || r > 0) begin
            rnd  = lcgNext();
            pick = int'(rnd[31:16] % 3);
            diff = r - t;
            if (t == 0) begin
                mv = dtwPkg::PathLeft;
            end else if (r == 0) begin
                mv = dtwPkg::PathUp;
            end else if (pick == 1 && diff < BandHalf) begin
                mv = dtwPkg::PathUp;
            end else if (pick == 2 && diff > -BandHalf) begin
                mv = dtwPkg::PathLeft;
            end else begin
                mv = dtwPkg::PathDiag;
            end
            dirMem[t + r][(NumPe - 1 - diff) / 2] = mv;  // Iteration t+r, PE from r-t.
            case (mv)
                dtwPkg::PathDiag: begin
                    t--;
                    r--;
                end
                dtwPkg::PathUp: t--;
                default: r--;
            endcase
        end
    endfunction

    // Reference walk; fills refTest/refRef and returns the step that reaches (0,0).
    function automatic int refWalk();
        dtwPkg::pathDir_e d;
        int               nit;
        int               pe;
        int               rem;
        int               t;
        int               r;
        int               s;
        int               endStep;
        nit     = NumWords - 1;
        pe      = 2;  // Middle of the band.
        rem     = 1;
        t       = SeqLen - 1;
        r       = SeqLen - 1;
        endStep = -1;
        for (s = 0; s <= MaxSteps; s++) begin
            refTest[s] = IndexWidth'(t);
            refRef[s]  = IndexWidth'(r);
            if (endStep < 0 && t == 0 && r == 0) begin
                endStep = s;
            end
            if (nit >= 0 && nit < NumWords && pe >= 0 && pe < NumPe) begin
                d = dirMem[nit][pe];
            end else begin
                d = dtwPkg::PathRst;  // No such word or slot.
            end
            case (d)
                dtwPkg::PathDiag: begin
                    nit = nit - 2;
                    t--;
                    r--;
                end
                dtwPkg::PathUp: begin
                    nit = nit - 1;
                    t--;
                    if (rem == 0) pe--;
                    rem = 1 - rem;
                end
                dtwPkg::PathLeft: begin
                    nit = nit - 1;
                    r--;
                    if (rem == 1) pe++;
                    rem = 1 - rem;
                end
                default: nit = nit - 1;
            endcase
        end
        return endStep;
    endfunction

    task automatic loadPath(input logic [ScoreWidth-1:0] score);
        int k;
        i_btEna   = 1'b0;
        i_btStart = 1'b0;
        i_score   = score;
        curScore  = score;
        for (k = 0; k < NumWords; k++) begin
            i_path = pathWord(k);
            @(posedge clk);
            #1;
        end
    endtask

    // Corner cell, no end flag, score hidden.
    task automatic checkIdle();
        logic [dtwPkg::DataWidth-1:0] expData;
        expData = dataWord(IndexWidth'(SeqLen - 1), IndexWidth'(SeqLen - 1), '0);
        @(negedge clk);
        if (o_data !== expData) begin
            $display("Mismatch at %0t: o_data expected %h, got %h", $time, expData, o_data);
            errCount++;
        end
        if (o_btEnd !== 1'b0) begin
            $display("Mismatch at %0t: o_btEnd expected 0, got %b", $time, o_btEnd);
            errCount++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic runTrace(input int stopStep, input bit toggleStart, output int seenEnd);
        logic [31:0] rnd;
        int          step;
        bit          done;
        seenEnd   = -1;
        done      = 1'b0;
        step      = 0;
        i_btEna   = 1'b1;
        i_btStart = 1'b1;
        traceStep = 0;
        checking  = 1'b1;
        while (!done) begin
            @(negedge clk);
            if (o_btEnd === 1'b1) begin
                seenEnd = step;
                done    = 1'b1;
            end else if (step >= stopStep) begin
                done = 1'b1;
            end
            @(posedge clk);
            #1;
            if (!done) begin
                step++;
                traceStep = step;
                if (toggleStart) begin
                    rnd       = lcgNext();
                    i_btStart = rnd[24];
                end
            end
        end
        checking = 1'b0;
    endtask

    task automatic checkEnd(input int seen, input int expected);
        if (seen < 0) begin
            $display("Error at %0t: o_btEnd never rose within %0d trace steps", $time, MaxSteps);
            errCount++;
        end else if (seen != expected) begin
            $display("Mismatch at %0t: o_btEnd step expected %0d, got %0d", $time, expected, seen);
            errCount++;
        end
    endtask

    task automatic endTest(input string name, input int errsBefore);
        testsRun++;
        if (errCount == errsBefore) begin
            $display("%s: PASS", name);
        end else begin
            testsFailed++;
            $display("%s: FAIL, %0d errors", name, errCount - errsBefore);
        end
    endtask

    // Compares every trace cycle against the reference walk.
    always @(negedge clk) begin
        logic [dtwPkg::DataWidth-1:0] expData;
        logic                         expEnd;
        if (checking) begin
            expData = dataWord(refTest[traceStep], refRef[traceStep],
                               i_btStart ? curScore : '0);
            expEnd  = (refTest[traceStep] == '0) && (refRef[traceStep] == '0);
            if (o_data !== expData) begin
                $display("Mismatch at %0t: o_data expected %h, got %h", $time, expData, o_data);
                errCount++;
            end
            if (o_btEnd !== expEnd) begin
                $display("Mismatch at %0t: o_btEnd expected %b, got %b", $time, expEnd, o_btEnd);
                errCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            $display("Timeout: run still going after %0d cycles", TimeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        int          errsBefore;
        int          expEnd;
        int          seenEnd;
        int          n;
        int          k;
        int          p;
        clk         = 1'b0;
        nrst        = 1'b0;
        i_score     = '0;
        i_path      = '0;
        i_btStart   = 1'b0;
        i_btEna     = 1'b0;
        curScore    = '0;
        lcgState    = 32'hc270d06a;
        checking    = 1'b0;
        traceStep   = 0;
        errCount    = 0;
        testsRun    = 0;
        testsFailed = 0;
        cycleCount  = 0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        nrst = 1'b1;

        errsBefore = errCount;
        checkIdle();
        endTest("Test 1 after reset", errsBefore);

        errsBefore = errCount;
        for (k = 0; k < NumWords; k++) begin
            for (p = 0; p < NumPe; p++) begin
                dirMem[k][p] = dtwPkg::PathDiag;
            end
        end
        loadPath(16'ha5c3);
        expEnd = refWalk();
        runTrace(MaxSteps, 1'b0, seenEnd);
        checkEnd(seenEnd, SeqLen - 1);  // One diagonal step per index.
        endTest("Test 2 all diagonal", errsBefore);

        errsBefore = errCount;
        for (n = 0; n < 3; n++) begin
            buildWalk();
            rnd = lcgNext();
            loadPath(rnd[31:16]);
            expEnd = refWalk();
            runTrace(MaxSteps, 1'b0, seenEnd);
            checkEnd(seenEnd, expEnd);
        end
        endTest("Test 3 random paths", errsBefore);

        errsBefore = errCount;
        buildWalk();
        rnd = lcgNext();
        loadPath(rnd[31:16]);
        expEnd = refWalk();
        runTrace(MaxSteps, 1'b1, seenEnd);
        checkEnd(seenEnd, expEnd);
        endTest("Test 4 score gating", errsBefore);

        errsBefore = errCount;
        buildWalk();
        rnd = lcgNext();
        loadPath(rnd[31:16]);
        expEnd = refWalk();
        runTrace(7, 1'b0, seenEnd);
        i_btEna   = 1'b0;  // Abort mid-trace.
        i_btStart = 1'b0;
        @(posedge clk);
        #1;
        checkIdle();
        buildWalk();
        rnd = lcgNext();
        loadPath(rnd[31:16]);
        expEnd = refWalk();
        runTrace(MaxSteps, 1'b0, seenEnd);
        checkEnd(seenEnd, expEnd);
        endTest("Test 5 restart", errsBefore);

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/dtwBacktraceChk.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtwBacktraceChk (
    input wire logic                         clk,
    input wire logic                         nrst,
    input wire logic                         i_btEna,
    input wire logic                         i_btStart,
    input wire logic                         o_btEnd,
    input wire logic [dtwPkg::DataWidth-1:0] o_data
);

    localparam int PadWidth   = dtwPkg::PadWidth;
    localparam int ScoreWidth = dtwPkg::ScoreWidth;
    localparam int TestPadLsb = dtwPkg::TestIdxLsb + dtwPkg::IndexWidth;  // Above test index.
    localparam int RefPadLsb  = dtwPkg::RefIdxLsb + dtwPkg::IndexWidth;   // Above ref index.

    // A load edge puts the walker back on the corner cell.
    endAfterLoad: assert property (
        @(posedge clk) disable iff (!nrst)
        !i_btEna |=> !o_btEnd
    ) else $error("o_btEnd high in the cycle after a load cycle");

    scoreGated: assert property (
        @(posedge clk) disable iff (!nrst)
        !i_btStart |-> (o_data[ScoreWidth-1:0] == '0)
    ) else $error("score field not zero while i_btStart is low");

    padsZero: assert property (
        @(posedge clk) disable iff (!nrst)
        (o_data[TestPadLsb +: PadWidth] == '0) && (o_data[RefPadLsb +: PadWidth] == '0)
    ) else $error("pad field of o_data not zero");

endmodule

`default_nettype wire

// ==== src/dtwBacktrace.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtwBacktrace #(
    parameter int NumPe  = 6,
    parameter int SeqLen = 20
) (
    input  wire logic                                 clk,
    input  wire logic                                 nrst,
    input  wire logic [dtwPkg::ScoreWidth-1:0]        i_score,
    input  wire logic [NumPe*dtwPkg::PathWidth-1:0]   i_path,
    input  wire logic                                 i_btStart,
    input  wire logic                                 i_btEna,
    output logic                                      o_btEnd,
    output logic [dtwPkg::DataWidth-1:0]              o_data
);

    localparam int NitWidth = $clog2(2 * SeqLen - 1);
    localparam int PeWidth  = $clog2(NumPe);

    logic [NitWidth-1:0] nit;  // Current anti-diagonal.
    logic [PeWidth-1:0]  pe;   // Current PE slot.
    dtwPkg::pathDir_e    dir;

    dtwPathStore #(
        .NumPe  (NumPe),
        .SeqLen (SeqLen)
    ) pathStore (
        .clk      (clk),
        .nrst     (nrst),
        .i_loadEn (!i_btEna),  // Load whenever the trace is off.
        .i_path   (i_path),
        .i_nit    (nit),
        .i_pe     (pe),
        .o_dir    (dir)
    );

    dtwTraceWalker #(
        .NumPe  (NumPe),
        .SeqLen (SeqLen)
    ) traceWalker (
        .clk       (clk),
        .nrst      (nrst),
        .i_btEna   (i_btEna),
        .i_btStart (i_btStart),
        .i_score   (i_score),
        .i_dir     (dir),
        .o_nit     (nit),
        .o_pe      (pe),
        .o_btEnd   (o_btEnd),
        .o_data    (o_data)
    );

endmodule

`default_nettype wire

// ==== src/dtwTraceWalker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtwTraceWalker #(
    parameter int NumPe  = 6,
    parameter int SeqLen = 20,
    localparam int NumWords = 2 * SeqLen - 1,
    localparam int NitWidth = $clog2(NumWords),
    localparam int PeWidth  = $clog2(NumPe)
) (
    input  wire logic                          clk,
    input  wire logic                          nrst,
    input  wire logic                          i_btEna,
    input  wire logic                          i_btStart,
    input  wire logic [dtwPkg::ScoreWidth-1:0] i_score,
    input  wire dtwPkg::pathDir_e              i_dir,
    output logic [NitWidth-1:0]                o_nit,
    output logic [PeWidth-1:0]                 o_pe,
    output logic                               o_btEnd,
    output logic [dtwPkg::DataWidth-1:0]       o_data
);

    localparam int IndexWidth = dtwPkg::IndexWidth;

    // The band is centred on t == r, so the corner cell lands on the middle PE.
    localparam logic [NitWidth-1:0]   StartNit = NitWidth'(NumWords - 1);
    localparam logic [PeWidth-1:0]    StartPe  = PeWidth'((NumPe - 1) / 2);
    localparam logic                  StartRem = 1'((NumPe - 1) % 2);
    localparam logic [IndexWidth-1:0] LastIdx  = IndexWidth'(SeqLen - 1);

    logic [NitWidth-1:0]           nit;
    logic [PeWidth-1:0]            pe;
    logic                          remHalf;  // Half step between PEs.
    logic [IndexWidth-1:0]         testIdx;
    logic [IndexWidth-1:0]         refIdx;
    logic [dtwPkg::ScoreWidth-1:0] scoreReg;

    // Position in the stored path: anti-diagonal and PE slot.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            nit     <= StartNit;
            pe      <= StartPe;
            remHalf <= StartRem;
        end else if (!i_btEna) begin
            nit     <= StartNit;
            pe      <= StartPe;
            remHalf <= StartRem;
        end else begin
            case (i_dir)
                dtwPkg::PathDiag: begin
                    nit <= nit - NitWidth'(2);  // Skips one anti-diagonal.
                end
                dtwPkg::PathUp: begin
                    nit <= nit - 1'b1;
                    if (!remHalf) begin
                        pe <= pe - 1'b1;
                    end
                    remHalf <= !remHalf;
                end
                dtwPkg::PathLeft: begin
                    nit <= nit - 1'b1;
                    if (remHalf) begin
                        pe <= pe + 1'b1;
                    end
                    remHalf <= !remHalf;
                end
                default: begin
                    nit <= nit - 1'b1;
                end
            endcase
        end
    end

    // Grid indices, starting from the last cell.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            testIdx <= LastIdx;
            refIdx  <= LastIdx;
        end else if (!i_btEna) begin
            testIdx <= LastIdx;
            refIdx  <= LastIdx;
        end else begin
            case (i_dir)
                dtwPkg::PathDiag: begin
                    testIdx <= testIdx - 1'b1;
                    refIdx  <= refIdx - 1'b1;
                end
                dtwPkg::PathUp: begin
                    testIdx <= testIdx - 1'b1;
                end
                dtwPkg::PathLeft: begin
                    refIdx <= refIdx - 1'b1;
                end
                default: begin
                    testIdx <= testIdx;  // Stay on the cell.
                end
            endcase
        end
    end

    // Final distance, held through the trace.
    always_ff @(posedge clk) begin
        if (!i_btEna) begin
            scoreReg <= i_score;
        end
    end

    assign o_nit   = nit;
    assign o_pe    = pe;
    assign o_btEnd = (testIdx == '0) && (refIdx == '0);

    always_comb begin
        o_data = '0;
        o_data[dtwPkg::TestIdxLsb +: IndexWidth] = testIdx;
        o_data[dtwPkg::RefIdxLsb +: IndexWidth]  = refIdx;
        if (i_btStart) begin
            o_data[dtwPkg::ScoreWidth-1:0] = scoreReg;  // Score only once started.
        end
    end

endmodule

`default_nettype wire

// ==== src/dtwPathStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtwPathStore #(
    parameter int NumPe  = 6,
    parameter int SeqLen = 20,
    localparam int NumWords  = 2 * SeqLen - 1,
    localparam int WordWidth = NumPe * dtwPkg::PathWidth,
    localparam int NitWidth  = $clog2(NumWords),
    localparam int PeWidth   = $clog2(NumPe)
) (
    input  wire logic                 clk,
    input  wire logic                 nrst,
    input  wire logic                 i_loadEn,
    input  wire logic [WordWidth-1:0] i_path,
    input  wire logic [NitWidth-1:0]  i_nit,
    input  wire logic [PeWidth-1:0]   i_pe,
    output dtwPkg::pathDir_e          o_dir
);

    logic [WordWidth-1:0]         pathMem [NumWords];  // Entry 0 is the newest word.
    logic [WordWidth-1:0]         curWord;
    logic [dtwPkg::PathWidth-1:0] slot [NumPe];
    logic                         nitValid;
    logic                         peValid;

    // One word per anti-diagonal, shifted in only while loading.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int k = 0; k < NumWords; k++) begin
                pathMem[k] <= '1;  // Every slot reads as a diagonal step.
            end
        end else if (i_loadEn) begin
            pathMem[0] <= i_path;
            for (int k = 1; k < NumWords; k++) begin
                pathMem[k] <= pathMem[k-1];
            end
        end
    end

    assign nitValid = (i_nit < NumWords);
    assign peValid  = (i_pe < NumPe);

    // Iteration k is the word loaded on cycle k, so it sits k words below the top.
    always_comb begin
        curWord = '0;
        if (nitValid) begin
            curWord = pathMem[NumWords - 1 - i_nit];
        end
    end

    // PE 0 owns the most significant code of a word.
    always_comb begin
        for (int p = 0; p < NumPe; p++) begin
            slot[p] = curWord[WordWidth - 1 - p * dtwPkg::PathWidth -: dtwPkg::PathWidth];
        end
    end

    always_comb begin
        o_dir = dtwPkg::PathRst;  // Off the band or past the first diagonal.
        if (nitValid && peValid) begin
            o_dir = dtwPkg::pathDir_e'(slot[i_pe]);
        end
    end

endmodule

`default_nettype wire

// ==== src/dtwPkg.sv ====
`default_nettype none

package dtwPkg;

    // Width of one direction code.
    localparam int PathWidth = 2;

    // Move taken from a cell during traceback.
    typedef enum logic [PathWidth-1:0] {
        PathRst  = 2'd0,  // No move.
        PathLeft = 2'd1,  // To (t, r-1).
        PathUp   = 2'd2,  // To (t-1, r).
        PathDiag = 2'd3   // To (t-1, r-1).
    } pathDir_e;

    localparam int ScoreWidth = 16;  // Final distance.
    localparam int IndexWidth = 5;   // Grid index.
    localparam int DataWidth  = 32;  // SRAM word.

    // SRAM word, top down: pad, test index, pad, reference index, score.
    localparam int PadWidth   = 3;
    localparam int RefIdxLsb  = ScoreWidth;
    localparam int TestIdxLsb = RefIdxLsb + IndexWidth + PadWidth;

endpackage

`default_nettype wire
